//--- hdl/muldiv_pkg.sv
package muldiv_pkg;

   // ##############################
   // widths
   // ##############################

   localparam int lg_w = 5;
   localparam int w = 1 << lg_w;
   localparam int w2 = 2 * w;             // hi in upper half, lo in lower.

   // ##############################
   // pointer sizes
   // ##############################

   localparam int lg_rob_entries = 6;
   localparam int lg_hilo_prf_entries = 4;
   localparam int hilo_prf_entries = 1 << lg_hilo_prf_entries;

   // ##############################
   // types
   // ##############################

   typedef logic [w-1:0] word_t;
   typedef logic [w2-1:0] dword_t;

   typedef logic [lg_rob_entries-1:0] rob_ptr_t;
   typedef logic [lg_hilo_prf_entries-1:0] hilo_ptr_t;

   // divider sequencing.
   typedef enum logic [1:0]
   {
      idle        = 2'd0,
      divide      = 2'd1,
      pack_output = 2'd2,
      wait_for_wb = 2'd3
   } div_state_t;

endpackage

//--- hdl/divider.sv
module divider
   import muldiv_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      start,
   input  logic      is_signed,
   input  word_t     src_a,
   input  word_t     src_b,
   input  rob_ptr_t  rob_ptr_in,
   input  hilo_ptr_t hilo_ptr_in,
   input  logic      grant,
   output dword_t    y,
   output rob_ptr_t  rob_ptr_out,
   output hilo_ptr_t hilo_ptr_out,
   output logic      ready,
   output logic      complete
);

   div_state_t r_state;
   div_state_t n_state;

   logic       r_is_signed;
   logic       r_quo_neg;          // operand signs differ.
   logic       r_rem_neg;          // dividend was negative.
   rob_ptr_t   r_rob_ptr;
   hilo_ptr_t  r_hilo_ptr;

   dword_t     r_rem;
   dword_t     r_den;
   word_t      r_quo;              // quotient shift register.
   dword_t     r_y;
   logic [lg_w-1:0] r_idx;

   word_t      t_mag_a;
   word_t      t_mag_b;
   dword_t     t_shift;
   logic       t_fits;
   word_t      t_quo_out;
   word_t      t_rem_out;

   // ##############################
   // operand conditioning
   // ##############################

   assign t_mag_a = (is_signed & src_a[w-1]) ? (~src_a + 1'b1) : src_a;
   assign t_mag_b = (is_signed & src_b[w-1]) ? (~src_b + 1'b1) : src_b;

   // one restoring step.
   assign t_shift = {r_rem[w2-2:0], 1'b0};
   assign t_fits = (t_shift >= r_den);

   // sign fixup for the packed result.
   assign t_quo_out = (r_is_signed & r_quo_neg) ? (~r_quo + 1'b1) : r_quo;
   assign t_rem_out = (r_is_signed & r_rem_neg) ? (~r_rem[w2-1:w] + 1'b1) : r_rem[w2-1:w];

   // ##############################
   // fsm
   // ##############################

   always_comb
   begin
      n_state = r_state;
      case (r_state)
         idle:
         begin
            if (start)
            begin
               n_state = divide;
            end
         end
         divide:
         begin
            if (r_idx == '0)
            begin
               n_state = pack_output;
            end
         end
         pack_output:
         begin
            n_state = wait_for_wb;
         end
         wait_for_wb:
         begin
            if (grant)                 // held until the port is ours.
            begin
               n_state = idle;
            end
         end
         default:
         begin
            n_state = idle;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= idle;
      end
      else
      begin
         r_state <= n_state;
      end
   end

   // ##############################
   // datapath
   // ##############################

   always_ff @(posedge clk)
   begin
      case (r_state)
         idle:
         begin
            r_rob_ptr <= rob_ptr_in;
            r_hilo_ptr <= hilo_ptr_in;
            r_is_signed <= is_signed;
            r_quo_neg <= src_a[w-1] ^ src_b[w-1];
            r_rem_neg <= src_a[w-1];
            r_rem <= {{w{1'b0}}, t_mag_a};
            r_den <= {t_mag_b, {w{1'b0}}};
            r_idx <= lg_w'(w - 1);
         end
         divide:
         begin
            r_rem <= t_fits ? (t_shift - r_den) : t_shift;
            r_quo <= {r_quo[w-2:0], t_fits};
            r_idx <= r_idx - 1'b1;
         end
         pack_output:
         begin
            r_y <= {t_rem_out, t_quo_out};   // remainder to hi.
         end
         default:
         begin
         end
      endcase
   end

   assign y = r_y;
   assign rob_ptr_out = r_rob_ptr;
   assign hilo_ptr_out = r_hilo_ptr;
   assign complete = (r_state == wait_for_wb);
   assign ready = (r_state == idle) & ~start;

endmodule

//--- hdl/multiplier.sv
module multiplier
   import muldiv_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      start,
   input  logic      is_signed,
   input  word_t     src_a,
   input  word_t     src_b,
   input  rob_ptr_t  rob_ptr_in,
   input  hilo_ptr_t hilo_ptr_in,
   output dword_t    y,
   output rob_ptr_t  rob_ptr_out,
   output hilo_ptr_t hilo_ptr_out,
   output logic      complete
);

   // stage one.
   logic              r_valid_1;
   logic signed [w:0] r_a;
   logic signed [w:0] r_b;
   rob_ptr_t          r_rob_ptr_1;
   hilo_ptr_t         r_hilo_ptr_1;

   // stage two.
   logic              r_valid_2;
   dword_t            r_prod;
   rob_ptr_t          r_rob_ptr_2;
   hilo_ptr_t         r_hilo_ptr_2;

   logic signed [w2+1:0] t_prod;

   // one extra bit covers both signed and unsigned operands.
   assign t_prod = r_a * r_b;

   // ##############################
   // valid pipe
   // ##############################

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_valid_1 <= 1'b0;
         r_valid_2 <= 1'b0;
      end
      else
      begin
         r_valid_1 <= start;
         r_valid_2 <= r_valid_1;
      end
   end

   // ##############################
   // payload pipe
   // ##############################

   always_ff @(posedge clk)
   begin
      r_a <= {is_signed & src_a[w-1], src_a};
      r_b <= {is_signed & src_b[w-1], src_b};
      r_rob_ptr_1 <= rob_ptr_in;
      r_hilo_ptr_1 <= hilo_ptr_in;

      r_prod <= t_prod[w2-1:0];             // low 64 bits are exact.
      r_rob_ptr_2 <= r_rob_ptr_1;
      r_hilo_ptr_2 <= r_hilo_ptr_1;
   end

   assign y = r_prod;
   assign rob_ptr_out = r_rob_ptr_2;
   assign hilo_ptr_out = r_hilo_ptr_2;
   assign complete = r_valid_2;

endmodule

//--- hdl/wb_arbiter.sv
module wb_arbiter
   import muldiv_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      mul_complete,
   input  dword_t    mul_y,
   input  rob_ptr_t  mul_rob_ptr,
   input  hilo_ptr_t mul_hilo_ptr,
   input  logic      div_complete,
   input  dword_t    div_y,
   input  rob_ptr_t  div_rob_ptr,
   input  hilo_ptr_t div_hilo_ptr,
   output logic      div_grant,
   output logic      wb_valid,
   output dword_t    wb_value,
   output rob_ptr_t  wb_rob_ptr,
   output hilo_ptr_t wb_hilo_ptr
);

   // multiplier pipe cannot stall, so it always wins.
   assign div_grant = div_complete & ~mul_complete;

   // ##############################
   // write-back register
   // ##############################

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wb_valid <= 1'b0;
      end
      else
      begin
         wb_valid <= mul_complete | div_complete;
      end
   end

   always_ff @(posedge clk)
   begin
      if (mul_complete)
      begin
         wb_value <= mul_y;
         wb_rob_ptr <= mul_rob_ptr;
         wb_hilo_ptr <= mul_hilo_ptr;
      end
      else
      begin
         wb_value <= div_y;              // don't care when idle.
         wb_rob_ptr <= div_rob_ptr;
         wb_hilo_ptr <= div_hilo_ptr;
      end
   end

endmodule

//--- hdl/hilo_regfile.sv
module hilo_regfile
   import muldiv_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      wb_valid,
   input  hilo_ptr_t wb_hilo_ptr,
   input  dword_t    wb_value,
   input  hilo_ptr_t rd_ptr,
   output dword_t    rd_value
);

   dword_t r_mem [hilo_prf_entries];

   // ##############################
   // write port
   // ##############################

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < hilo_prf_entries; i++)
         begin
            r_mem[i] <= '0;
         end
      end
      else if (wb_valid)
      begin
         r_mem[wb_hilo_ptr] <= wb_value;
      end
   end

   // combinational read without bypass.
   assign rd_value = r_mem[rd_ptr];

endmodule

//--- hdl/muldiv_unit.sv
module muldiv_unit
   import muldiv_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      start,
   input  logic      is_div,
   input  logic      is_signed,
   input  word_t     src_a,
   input  word_t     src_b,
   input  rob_ptr_t  rob_ptr_in,
   input  hilo_ptr_t hilo_ptr_in,
   input  hilo_ptr_t rd_ptr,
   output logic      div_ready,
   output logic      wb_valid,
   output dword_t    wb_value,
   output rob_ptr_t  wb_rob_ptr,
   output hilo_ptr_t wb_hilo_ptr,
   output dword_t    rd_value
);

   logic      mul_start;
   logic      div_start;

   logic      mul_complete;
   dword_t    mul_y;
   rob_ptr_t  mul_rob_ptr;
   hilo_ptr_t mul_hilo_ptr;

   logic      div_complete;
   dword_t    div_y;
   rob_ptr_t  div_rob_ptr;
   hilo_ptr_t div_hilo_ptr;
   logic      div_grant;

   // issue steering.
   assign mul_start = start & ~is_div;
   assign div_start = start & is_div;

   // ##############################
   // execution peers
   // ##############################

   multiplier i_multiplier
   (
      .clk          (clk),
      .reset        (reset),
      .start        (mul_start),
      .is_signed    (is_signed),
      .src_a        (src_a),
      .src_b        (src_b),
      .rob_ptr_in   (rob_ptr_in),
      .hilo_ptr_in  (hilo_ptr_in),
      .y            (mul_y),
      .rob_ptr_out  (mul_rob_ptr),
      .hilo_ptr_out (mul_hilo_ptr),
      .complete     (mul_complete)
   );

   divider i_divider
   (
      .clk          (clk),
      .reset        (reset),
      .start        (div_start),
      .is_signed    (is_signed),
      .src_a        (src_a),
      .src_b        (src_b),
      .rob_ptr_in   (rob_ptr_in),
      .hilo_ptr_in  (hilo_ptr_in),
      .grant        (div_grant),
      .y            (div_y),
      .rob_ptr_out  (div_rob_ptr),
      .hilo_ptr_out (div_hilo_ptr),
      .ready        (div_ready),
      .complete     (div_complete)
   );

   // ##############################
   // write-back and storage
   // ##############################

   wb_arbiter i_wb_arbiter
   (
      .clk          (clk),
      .reset        (reset),
      .mul_complete (mul_complete),
      .mul_y        (mul_y),
      .mul_rob_ptr  (mul_rob_ptr),
      .mul_hilo_ptr (mul_hilo_ptr),
      .div_complete (div_complete),
      .div_y        (div_y),
      .div_rob_ptr  (div_rob_ptr),
      .div_hilo_ptr (div_hilo_ptr),
      .div_grant    (div_grant),
      .wb_valid     (wb_valid),
      .wb_value     (wb_value),
      .wb_rob_ptr   (wb_rob_ptr),
      .wb_hilo_ptr  (wb_hilo_ptr)
   );

   hilo_regfile i_hilo_regfile
   (
      .clk          (clk),
      .reset        (reset),
      .wb_valid     (wb_valid),
      .wb_hilo_ptr  (wb_hilo_ptr),
      .wb_value     (wb_value),
      .rd_ptr       (rd_ptr),
      .rd_value     (rd_value)
   );

endmodule

//--- testbench/tb_muldiv_table.svh
   // each set_row call gives row, is_div, is_signed, src_a and src_b.
   // set_row works out the expected result of each row.

   task automatic load_table();
      int    k;
      logic  op_div;
      word_t a;
      word_t b;
      word_t r;

      // ##############################
      // fixed corner cases
      // ##############################

      set_row(0,  1'b0, 1'b1, 32'hffff_fffd, 32'hffff_fff9);   // neg x neg.
      set_row(1,  1'b0, 1'b1, 32'h8000_0000, 32'h8000_0000);
      set_row(2,  1'b0, 1'b0, 32'h8000_0000, 32'h8000_0000);
      set_row(3,  1'b0, 1'b0, 32'hffff_ffff, 32'hffff_ffff);
      set_row(4,  1'b0, 1'b1, 32'hffff_ffff, 32'hffff_ffff);
      set_row(5,  1'b0, 1'b1, 32'h7fff_ffff, 32'h8000_0000);
      set_row(6,  1'b0, 1'b1, 32'h0000_1234, 32'hffff_0000);
      set_row(7,  1'b0, 1'b0, 32'h0000_0000, 32'hdead_beef);
      set_row(8,  1'b1, 1'b1, 32'hffff_ff9c, 32'h0000_0007);   // -100 / 7.
      set_row(9,  1'b1, 1'b1, 32'h0000_0064, 32'hffff_fff9);
      set_row(10, 1'b1, 1'b1, 32'hffff_ff9c, 32'hffff_fff9);
      set_row(11, 1'b1, 1'b0, 32'hffff_ff9c, 32'h0000_0007);
      set_row(12, 1'b1, 1'b1, 32'h8000_0000, 32'hffff_ffff);
      set_row(13, 1'b1, 1'b0, 32'h1234_5678, 32'h0000_0000);   // divide by zero.
      set_row(14, 1'b1, 1'b1, 32'hffff_fff6, 32'h0000_0000);
      set_row(15, 1'b1, 1'b1, 32'h0000_000a, 32'h0000_0000);
      set_row(16, 1'b1, 1'b0, 32'hffff_ffff, 32'h0000_0001);
      set_row(17, 1'b0, 1'b1, 32'h0000_0001, 32'hffff_ffff);
      set_row(18, 1'b1, 1'b1, 32'h0bad_cafe, 32'h0000_0123);   // overlapped by the burst.

      // ##############################
      // random rows
      // ##############################

      for (k = n_fixed; k < n_ops; k++)
      begin
         a = next_rand();
         b = next_rand();
         r = next_rand();
         op_div = (k >= n_fixed + n_burst) ? r[7] : 1'b0;
         if (op_div)
         begin
            b = b >> r[4:0];            // smaller divisors give longer quotients.
         end
         set_row(k, op_div, r[0], a, b);
      end
   endtask

//--- testbench/tb_muldiv_unit.sv
module tb_muldiv_unit
   import muldiv_pkg::*;
();

   localparam int n_fixed = 19;
   localparam int n_burst = 36;          // multiplies right after the last fixed divide.
   localparam int n_random = 40;
   localparam int n_ops = n_fixed + n_random;
   localparam int mul_wb_lat = 2;        // edges after the issue edge.
   localparam int timeout_cycles = n_ops * (w + 6) + 100;

   logic      clk;
   logic      reset;
   logic      start;
   logic      is_div;
   logic      is_signed;
   word_t     src_a;
   word_t     src_b;
   rob_ptr_t  rob_ptr_in;
   hilo_ptr_t hilo_ptr_in;
   hilo_ptr_t rd_ptr;
   logic      div_ready;
   logic      wb_valid;
   dword_t    wb_value;
   rob_ptr_t  wb_rob_ptr;
   hilo_ptr_t wb_hilo_ptr;
   dword_t    rd_value;

   // stimulus table and expected results.
   logic   tab_is_div [n_ops];
   logic   tab_is_signed [n_ops];
   word_t  tab_a [n_ops];
   word_t  tab_b [n_ops];
   dword_t tab_exp [n_ops];

   logic   issued [n_ops];
   logic   done [n_ops];
   int     issue_cyc [n_ops];
   dword_t shadow [hilo_prf_entries];    // expected register file.

   logic [31:0] rng_state;
   int          cyc = 0;
   int          n_done;
   logic        div_busy;

   muldiv_unit i_dut
   (
      .clk         (clk),
      .reset       (reset),
      .start       (start),
      .is_div      (is_div),
      .is_signed   (is_signed),
      .src_a       (src_a),
      .src_b       (src_b),
      .rob_ptr_in  (rob_ptr_in),
      .hilo_ptr_in (hilo_ptr_in),
      .rd_ptr      (rd_ptr),
      .div_ready   (div_ready),
      .wb_valid    (wb_valid),
      .wb_value    (wb_value),
      .wb_rob_ptr  (wb_rob_ptr),
      .wb_hilo_ptr (wb_hilo_ptr),
      .rd_value    (rd_value)
   );

   // ##############################
   // reference model
   // ##############################

   function automatic word_t next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic dword_t expected_result(input logic op_div, input logic op_signed,
                                              input word_t a, input word_t b);
      dword_t ext_a;
      dword_t ext_b;
      logic   neg_a;
      logic   neg_b;
      word_t  mag_a;
      word_t  mag_b;
      word_t  q;
      word_t  r;
      ext_a = op_signed ? {{w{a[w-1]}}, a} : {{w{1'b0}}, a};
      ext_b = op_signed ? {{w{b[w-1]}}, b} : {{w{1'b0}}, b};
      if (!op_div)
      begin
         return ext_a * ext_b;           // 64-bit wrap equals the true product.
      end
      neg_a = op_signed & a[w-1];
      neg_b = op_signed & b[w-1];
      mag_a = neg_a ? -a : a;
      mag_b = neg_b ? -b : b;
      if (mag_b == '0)
      begin
         q = '1;
         r = mag_a;
      end
      else
      begin
         q = mag_a / mag_b;
         r = mag_a % mag_b;
      end
      q = (neg_a ^ neg_b) ? -q : q;
      r = neg_a ? -r : r;                // remainder follows the dividend.
      return {r, q};
   endfunction

   task automatic set_row(input int k, input logic op_div, input logic op_signed,
                          input word_t a, input word_t b);
      tab_is_div[k] = op_div;
      tab_is_signed[k] = op_signed;
      tab_a[k] = a;
      tab_b[k] = b;
      tab_exp[k] = expected_result(op_div, op_signed, a, b);
   endtask

   `include "tb_muldiv_table.svh"

   // ##############################
   // checks
   // ##############################

   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input dword_t exp, input dword_t act);
      if (act !== exp)
      begin
         stop_with_failure($sformatf("** Error: %s expected %h, got %h", name, exp, act));
      end
   endtask

   task automatic check_rob(input string name, input rob_ptr_t exp, input rob_ptr_t act);
      if (act !== exp)
      begin
         stop_with_failure($sformatf("** Error: %s expected %h, got %h", name, exp, act));
      end
   endtask

   task automatic check_hilo(input string name, input hilo_ptr_t exp, input hilo_ptr_t act);
      if (act !== exp)
      begin
         stop_with_failure($sformatf("** Error: %s expected %h, got %h", name, exp, act));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         stop_with_failure($sformatf("** Error: %s expected %h, got %h", name, exp, act));
      end
   endtask

   task automatic record(input int k);
      if (done[k])
      begin
         stop_with_failure($sformatf("operation %0d completed a second time", k));
      end
      check_value("wb_value", tab_exp[k], wb_value);
      check_hilo("wb_hilo_ptr", hilo_ptr_t'(k % hilo_prf_entries), wb_hilo_ptr);
      done[k] = 1'b1;
      n_done++;
      shadow[k % hilo_prf_entries] = tab_exp[k];
   endtask

   // called once per falling edge while outputs are settled.
   task automatic observe();
      int i;
      int due;
      int k;
      due = -1;
      for (i = 0; i < n_ops; i++)
      begin
         if (issued[i] && !tab_is_div[i] && issue_cyc[i] == cyc - mul_wb_lat)
         begin
            due = i;
         end
      end
      if (due >= 0)
      begin
         check_bit("wb_valid", 1'b1, wb_valid);  // multiplies never wait.
         check_rob("wb_rob_ptr", rob_ptr_t'(due), wb_rob_ptr);
         record(due);
      end
      else if (wb_valid)
      begin
         k = int'(wb_rob_ptr);
         if (k >= n_ops || !issued[k])
         begin
            stop_with_failure("write-back for an operation that was never issued");
         end
         record(k);
         if (!tab_is_div[k])
         begin
            stop_with_failure($sformatf("multiply %0d written back outside its slot", k));
         end
         if (cyc - issue_cyc[k] < w + 2)
         begin
            stop_with_failure("divide result written back too early");
         end
         div_busy = 1'b0;
      end
      check_bit("div_ready", ~div_busy, div_ready);
   endtask

   // ##############################
   // drivers
   // ##############################

   task automatic drive_op(input int k);
      start = 1'b1;
      is_div = tab_is_div[k];
      is_signed = tab_is_signed[k];
      src_a = tab_a[k];
      src_b = tab_b[k];
      rob_ptr_in = rob_ptr_t'(k);
      hilo_ptr_in = hilo_ptr_t'(k % hilo_prf_entries);
      issued[k] = 1'b1;
      issue_cyc[k] = cyc + 1;            // count after the next rising edge.
      if (tab_is_div[k])
      begin
         div_busy = 1'b1;
      end
   endtask

   task automatic drive_idle();
      start = 1'b0;
   endtask

   task automatic check_regfile();
      int p;
      for (p = 0; p < hilo_prf_entries; p++)
      begin
         rd_ptr = hilo_ptr_t'(p);
         @(negedge clk);
         observe();
         check_value("rd_value", shadow[p], rd_value);
      end
   endtask

   // ##############################
   // clock, timeout, sequence
   // ##############################

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cyc <= cyc + 1;
      if (cyc >= timeout_cycles)
      begin
         stop_with_failure($sformatf("timed out after %0d cycles", cyc));
      end
   end

   initial
   begin
      int k;
      reset = 1'b1;
      start = 1'b0;
      is_div = 1'b0;
      is_signed = 1'b0;
      src_a = '0;
      src_b = '0;
      rob_ptr_in = '0;
      hilo_ptr_in = '0;
      rd_ptr = '0;
      n_done = 0;
      div_busy = 1'b0;
      rng_state = 32'd93310;
      for (k = 0; k < n_ops; k++)
      begin
         issued[k] = 1'b0;
         done[k] = 1'b0;
         issue_cyc[k] = 0;
      end
      for (k = 0; k < hilo_prf_entries; k++)
      begin
         shadow[k] = '0;
      end
      load_table();

      repeat (16) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      observe();
      check_regfile();                   // all zero after reset.

      for (k = 0; k < n_ops; k++)
      begin
         @(negedge clk);
         observe();
         while (tab_is_div[k] && !div_ready)
         begin
            drive_idle();
            @(negedge clk);
            observe();
         end
         drive_op(k);
      end
      while (n_done < n_ops)
      begin
         @(negedge clk);
         observe();
         drive_idle();
      end
      repeat (4)
      begin
         @(negedge clk);
         observe();
      end
      check_regfile();

      if (n_done == n_ops)
      begin
         $display("All checks passed");
         $finish;
      end
      else
      begin
         stop_with_failure("not every operation completed");
      end
   end

endmodule

//--- files.f
+incdir+testbench
hdl/muldiv_pkg.sv
hdl/divider.sv
hdl/multiplier.sv
hdl/wb_arbiter.sv
hdl/hilo_regfile.sv
hdl/muldiv_unit.sv
testbench/tb_muldiv_unit.sv
